// File: logic/sdcmd_pkg.sv
`default_nettype none

package sdcmd_pkg;

    // Command field widths
    localparam int CMD_INDEX_W = 6;
    localparam int CMD_ARG_W   = 32;
    localparam int CRC7_W      = 7;
    localparam int FRAME_W     = 48;

    // Protocol timing in SD clocks
    localparam int PREINIT_CLOCKS = 74; // CMD high after power-up
    localparam int GAP_CLOCKS     = 8;  // Minimum idle between frames

    // Native-mode command frame, MSB goes out first
    typedef struct packed {
        logic                   start_bit; // Always 0
        logic                   tx_bit;    // 1 for host to card
        logic [CMD_INDEX_W-1:0] index;
        logic [CMD_ARG_W-1:0]   arg;
        logic [CRC7_W-1:0]      crc;
        logic                   end_bit;   // Always 1
    } cmd_frame_t;

endpackage

`default_nettype wire

// File: logic/sdcmd_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module sdcmd_clkgen #(
    parameter int CLK_DIV = 2 // System clocks per SD half-period
) (
    input  logic i_clk,
    input  logic i_nrst,
    output logic o_sclk,
    output logic o_sclk_rise,
    output logic o_sclk_fall
);

    localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CNT_W-1:0] half_cnt;
    logic             toggle;

    assign toggle = (half_cnt == CNT_W'(CLK_DIV - 1));

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            half_cnt    <= '0;
            o_sclk      <= 1'b0;
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end else begin
            half_cnt    <= toggle ? '0 : half_cnt + 1'b1;
            // Strobes line up with the new level of o_sclk
            o_sclk_rise <= toggle && !o_sclk;
            o_sclk_fall <= toggle && o_sclk;
            if (toggle) begin
                o_sclk <= !o_sclk;
            end
        end
    end

    // Edges alternate, so only one strobe per cycle
    a_one_edge: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        !(o_sclk_rise && o_sclk_fall)
    );

endmodule

`default_nettype wire

// File: logic/sdcmd_framer.sv
`timescale 1ns/1ps
`default_nettype none

module sdcmd_framer
    import sdcmd_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_req_valid,
    input  logic [CMD_INDEX_W-1:0] i_req_index,
    input  logic [CMD_ARG_W-1:0]   i_req_arg,
    output logic                   o_wr_valid,
    output cmd_frame_t             o_wr_frame
);

    // Start, transmission, index and argument are covered by the CRC
    localparam int BODY_W = 2 + CMD_INDEX_W + CMD_ARG_W;
    localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09; // x^7 + x^3 + 1

    function automatic logic [CRC7_W-1:0] crc7_calc(input logic [BODY_W-1:0] body);
        logic [CRC7_W-1:0] crc;
        logic              fb;
        crc = '0;
        for (int i = BODY_W - 1; i >= 0; i--) begin
            fb  = body[i] ^ crc[CRC7_W-1];
            crc = {crc[CRC7_W-2:0], 1'b0} ^ ({CRC7_W{fb}} & CRC7_POLY);
        end
        return crc;
    endfunction

    cmd_frame_t next_frame;

    always_comb begin
        next_frame.start_bit = 1'b0;
        next_frame.tx_bit    = 1'b1;
        next_frame.index     = i_req_index;
        next_frame.arg       = i_req_arg;
        next_frame.crc       = crc7_calc({2'b01, i_req_index, i_req_arg});
        next_frame.end_bit   = 1'b1;
    end

    // Frame register, loaded on request only
    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            o_wr_frame <= next_frame;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_wr_valid <= 1'b0;
        end else begin
            o_wr_valid <= i_req_valid; // One cycle behind the request
        end
    end

endmodule

`default_nettype wire

// File: logic/sdcmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sdcmd_fifo
    import sdcmd_pkg::*;
#(
    parameter int FIFO_DEPTH = 4 // Power of two, 2 or more
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_wr_valid,
    input  cmd_frame_t i_wr_frame,
    input  logic       i_rd_pop,
    output cmd_frame_t o_rd_frame,
    output logic       o_empty,
    output logic       o_overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    cmd_frame_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign o_empty = (count == '0);
    assign rd_ok   = i_rd_pop && !o_empty;
    // A pop in the same cycle frees the slot being written
    assign wr_ok   = i_wr_valid && (!full || rd_ok);

    assign o_rd_frame = mem[rd_ptr]; // Oldest entry

    always_ff @(posedge i_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_frame;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at the power-of-two depth
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (i_wr_valid && !wr_ok) begin
                o_overflow <= 1'b1; // Sticky until reset
            end
        end
    end

    // The serializer only pops what it has seen present
    a_no_pop_empty: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_rd_pop |-> !o_empty
    );

endmodule

`default_nettype wire

// File: logic/sdcmd_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module sdcmd_serializer
    import sdcmd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_sclk_rise,
    input  logic       i_sclk_fall,
    input  logic       i_empty,
    input  cmd_frame_t i_rd_frame,
    output logic       o_rd_pop,
    output logic       o_cmd
);

    localparam int CNT_W = $clog2(PREINIT_CLOCKS);
    localparam int BIT_W = $clog2(FRAME_W);

    typedef enum logic [1:0] {
        ST_PREINIT,
        ST_GAP,
        ST_IDLE,
        ST_SHIFT
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   clk_cnt;   // Rising edges seen in pre-init or gap
    logic [BIT_W-1:0]   bits_left;
    logic [FRAME_W-1:0] shreg;

    // Start a frame on a falling edge once idle and data is waiting
    assign o_rd_pop = (state == ST_IDLE) && i_sclk_fall && !i_empty;

    always_ff @(posedge i_clk) begin
        if (o_rd_pop) begin
            shreg <= {i_rd_frame[FRAME_W-2:0], 1'b0}; // Bit 47 goes straight out
        end else if (state == ST_SHIFT && i_sclk_fall) begin
            shreg <= {shreg[FRAME_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= ST_PREINIT;
            clk_cnt   <= '0;
            bits_left <= '0;
            o_cmd     <= 1'b1;
        end else begin
            case (state)
                ST_PREINIT, ST_GAP: begin
                    if (i_sclk_rise) begin
                        if ((state == ST_PREINIT && clk_cnt == CNT_W'(PREINIT_CLOCKS - 1))
                            || (state == ST_GAP && clk_cnt == CNT_W'(GAP_CLOCKS - 1))) begin
                            state   <= ST_IDLE;
                            clk_cnt <= '0;
                        end else begin
                            clk_cnt <= clk_cnt + 1'b1;
                        end
                    end
                end
                ST_IDLE: begin
                    if (o_rd_pop) begin
                        state     <= ST_SHIFT;
                        o_cmd     <= i_rd_frame[FRAME_W-1];
                        bits_left <= BIT_W'(FRAME_W - 1);
                    end
                end
                default: begin
                    if (i_sclk_fall) begin
                        if (bits_left != '0) begin
                            o_cmd     <= shreg[FRAME_W-1];
                            bits_left <= bits_left - 1'b1;
                        end else begin
                            // End bit has had its full period
                            state   <= ST_GAP;
                            clk_cnt <= '0;
                            o_cmd   <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Line idles high in pre-init, gap and idle
    a_cmd_idle_high: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (state != ST_SHIFT) |-> o_cmd
    );

endmodule

`default_nettype wire

// File: logic/sdcmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdcmd_top
    import sdcmd_pkg::*;
#(
    parameter int CLK_DIV    = 2, // System clocks per SD half-period
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_req_valid,
    input  logic [CMD_INDEX_W-1:0] i_req_index,
    input  logic [CMD_ARG_W-1:0]   i_req_arg,
    output logic                   o_sclk,
    output logic                   o_cmd,
    output logic                   o_overflow
);

    logic       sclk_rise;
    logic       sclk_fall;
    logic       wr_valid;
    cmd_frame_t wr_frame;
    logic       rd_pop;
    cmd_frame_t rd_frame;
    logic       fifo_empty;

    sdcmd_clkgen #(
        .CLK_DIV(CLK_DIV)
    ) sdcmd_clkgen_inst (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .o_sclk     (o_sclk),
        .o_sclk_rise(sclk_rise),
        .o_sclk_fall(sclk_fall)
    );

    sdcmd_framer sdcmd_framer_inst (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req_valid(i_req_valid),
        .i_req_index(i_req_index),
        .i_req_arg  (i_req_arg),
        .o_wr_valid (wr_valid),
        .o_wr_frame (wr_frame)
    );

    sdcmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) sdcmd_fifo_inst (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_wr_valid(wr_valid),
        .i_wr_frame(wr_frame),
        .i_rd_pop  (rd_pop),
        .o_rd_frame(rd_frame),
        .o_empty   (fifo_empty),
        .o_overflow(o_overflow)
    );

    sdcmd_serializer sdcmd_serializer_inst (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_sclk_rise(sclk_rise),
        .i_sclk_fall(sclk_fall),
        .i_empty    (fifo_empty),
        .i_rd_frame (rd_frame),
        .o_rd_pop   (rd_pop),
        .o_cmd      (o_cmd)
    );

endmodule

`default_nettype wire

// File: verif/tb_sdcmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdcmd
    import sdcmd_pkg::*;
();

    localparam int CLK_DIV       = 2;
    localparam int FIFO_DEPTH    = 4;
    localparam int CLK_PERIOD_NS = 10;
    localparam int RESET_CYCLES  = 3;
    localparam int N_SPACED      = 12;
    localparam int BURST_LEN     = FIFO_DEPTH + 3;
    localparam int MAX_PENDING   = 3; // Keeps the spaced phase clear of overflow
    localparam int QUIET_RISES   = 2 * GAP_CLOCKS + 4;
    localparam int SD_PERIOD_NS  = 2 * CLK_DIV * CLK_PERIOD_NS;
    localparam int TIMEOUT_NS    = ((N_SPACED + BURST_LEN) * FRAME_W * 4 + PREINIT_CLOCKS)
                                   * SD_PERIOD_NS + RESET_CYCLES * CLK_PERIOD_NS;

    logic                   i_clk;
    logic                   i_nrst;
    logic                   i_req_valid;
    logic [CMD_INDEX_W-1:0] i_req_index;
    logic [CMD_ARG_W-1:0]   i_req_arg;
    logic                   o_sclk;
    logic                   o_cmd;
    logic                   o_overflow;

    logic [31:0]        lfsr_state;
    logic [FRAME_W-1:0] exp_q[$];        // Expected frames in request order
    int                 sent_count;
    int                 frames_captured;
    int                 burst_matched;
    logic               burst_mode;
    int                 ovf_mode;        // 0 low, 1 either, 2 high

    // Monitor state
    logic               sclk_prev;
    logic               seen_rise;
    logic               first_frame_seen;
    logic               in_frame;
    int                 clk_since_rise;
    int                 high_run;        // High CMD samples outside a frame
    int                 bit_cnt;
    logic [FRAME_W-1:0] shift_frame;

    sdcmd_top #(
        .CLK_DIV   (CLK_DIV),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) sdcmd_top_inst (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_req_valid(i_req_valid),
        .i_req_index(i_req_index),
        .i_req_arg  (i_req_arg),
        .o_sclk     (o_sclk),
        .o_cmd      (o_cmd),
        .o_overflow (o_overflow)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;
    end

    task automatic end_run_failed();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[FAIL] time %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        end_run_failed();
    endtask

    task automatic report_problem(input string what);
        $display("Error at time %0t: %s", $time, what);
        end_run_failed();
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Long division of the body times x^7 by x^7 + x^3 + 1
    function automatic logic [CRC7_W-1:0] crc7_model(input logic [39:0] body);
        logic [46:0] rem;
        rem = {body, 7'b0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'h89;
            end
        end
        return rem[6:0];
    endfunction

    function automatic logic [FRAME_W-1:0] expected_frame(input logic [CMD_INDEX_W-1:0] idx,
                                                          input logic [CMD_ARG_W-1:0] arg);
        return {1'b0, 1'b1, idx, arg, crc7_model({1'b0, 1'b1, idx, arg}), 1'b1};
    endfunction

    task automatic send_random_request();
        logic [31:0] idx_bits;
        logic [31:0] arg_bits;
        idx_bits = take_bits(CMD_INDEX_W);
        arg_bits = take_bits(CMD_ARG_W);
        @(posedge i_clk);
        i_req_valid <= 1'b1;
        i_req_index <= idx_bits[CMD_INDEX_W-1:0];
        i_req_arg   <= arg_bits;
        exp_q.push_back(expected_frame(idx_bits[CMD_INDEX_W-1:0], arg_bits));
        sent_count++;
    endtask

    task automatic check_frame(input logic [FRAME_W-1:0] frame);
        if (burst_mode) begin
            // Dropped requests are skipped, order must hold
            while (exp_q.size() > 0 && exp_q[0] != frame) begin
                void'(exp_q.pop_front());
            end
            assert (exp_q.size() > 0)
                else report_problem($sformatf("frame 0x%012h is not an in-order burst request",
                                              frame));
            burst_matched++;
        end else begin
            assert (exp_q.size() > 0)
                else report_problem("a frame appeared on CMD with no request outstanding");
            assert (frame == exp_q[0])
                else report_mismatch("o_cmd frame", 64'(exp_q[0]), 64'(frame));
        end
        void'(exp_q.pop_front());
        frames_captured++;
    endtask

    task automatic sample_cmd();
        if (!in_frame) begin
            if (o_cmd === 1'b0) begin
                if (!first_frame_seen) begin
                    assert (high_run >= PREINIT_CLOCKS)
                        else report_problem($sformatf(
                            "CMD high for only %0d SD clocks before the first frame", high_run));
                end else begin
                    assert (high_run >= GAP_CLOCKS)
                        else report_problem($sformatf(
                            "CMD high for only %0d SD clocks between frames", high_run));
                end
                in_frame    = 1'b1;
                bit_cnt     = 1;
                shift_frame = '0; // Start bit already in place
            end else begin
                high_run++;
            end
        end else begin
            shift_frame = {shift_frame[FRAME_W-2:0], o_cmd};
            bit_cnt++;
            if (bit_cnt == FRAME_W) begin
                in_frame         = 1'b0;
                high_run         = 0;
                first_frame_seen = 1'b1;
                check_frame(shift_frame);
            end
        end
    endtask

    // Sampled on the falling system clock, away from DUT updates
    always @(negedge i_clk) begin
        if (i_nrst !== 1'b1) begin
            sclk_prev        = 1'b0;
            seen_rise        = 1'b0;
            first_frame_seen = 1'b0;
            in_frame         = 1'b0;
            clk_since_rise   = 0;
            high_run         = 0;
            bit_cnt          = 0;
            frames_captured  = 0;
            burst_matched    = 0;
        end else begin
            if (ovf_mode == 0) begin
                assert (o_overflow === 1'b0)
                    else report_mismatch("o_overflow", 64'd0, 64'(o_overflow));
            end else if (ovf_mode == 2) begin
                assert (o_overflow === 1'b1)
                    else report_mismatch("o_overflow", 64'd1, 64'(o_overflow));
            end
            clk_since_rise++;
            if (o_sclk && !sclk_prev) begin
                if (seen_rise) begin
                    assert (clk_since_rise == 2 * CLK_DIV)
                        else report_mismatch("o_sclk period", 64'(2 * CLK_DIV),
                                             64'(clk_since_rise));
                end
                seen_rise      = 1'b1;
                clk_since_rise = 0;
                sample_cmd();
            end
            sclk_prev = o_sclk;
        end
    end

    initial begin
        logic [31:0] gap_bits;
        lfsr_state  = 32'h46cb_4655;
        sent_count  = 0;
        burst_mode  = 1'b0;
        ovf_mode    = 0;
        i_nrst      <= 1'b0;
        i_req_valid <= 1'b0;
        i_req_index <= '0;
        i_req_arg   <= '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        assert (o_cmd === 1'b1) else report_mismatch("o_cmd", 64'd1, 64'(o_cmd));
        assert (o_sclk === 1'b0) else report_mismatch("o_sclk", 64'd0, 64'(o_sclk));
        assert (o_overflow === 1'b0)
            else report_mismatch("o_overflow", 64'd0, 64'(o_overflow));
        i_nrst <= 1'b1;

        // Spaced requests with random idle time
        for (int n = 0; n < N_SPACED; n++) begin
            while (sent_count - frames_captured >= MAX_PENDING) @(posedge i_clk);
            send_random_request();
            @(posedge i_clk);
            i_req_valid <= 1'b0;
            gap_bits = take_bits(4);
            repeat (gap_bits[3:0]) @(posedge i_clk);
        end
        while (frames_captured < sent_count) @(posedge i_clk);

        // Back-to-back burst overruns the FIFO
        burst_mode = 1'b1;
        ovf_mode   = 1;
        for (int n = 0; n < BURST_LEN; n++) begin
            send_random_request();
        end
        @(posedge i_clk);
        i_req_valid <= 1'b0;
        repeat (3) @(posedge i_clk); // Framer and FIFO latency
        ovf_mode = 2;
        while (frames_captured == N_SPACED) @(posedge i_clk);
        while (in_frame || high_run < QUIET_RISES) @(posedge i_clk);
        assert (burst_matched >= FIFO_DEPTH)
            else report_problem($sformatf("only %0d of %0d burst frames reached CMD",
                                          burst_matched, BURST_LEN));
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        report_problem($sformatf("watchdog expired after %0d ns without finishing the tests",
                                 TIMEOUT_NS));
    end

endmodule

`default_nettype wire

// File: list.f
logic/sdcmd_pkg.sv
logic/sdcmd_clkgen.sv
logic/sdcmd_framer.sv
logic/sdcmd_fifo.sv
logic/sdcmd_serializer.sv
logic/sdcmd_top.sv
verif/tb_sdcmd.sv

// File: Makefile
# Verilator flow for the SD command path

VERILATOR ?= verilator
TOP       ?= tb_sdcmd
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --timing --assert

SRCS := $(wildcard logic/*.sv verif/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a non-zero exit status
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)
